// File: istream_macros.svh
`ifndef ISTREAM_MACROS_SVH
`define ISTREAM_MACROS_SVH

// ------------------------------------------------------------
// stream buffer sizing
// ------------------------------------------------------------

// two-byte parcels per fetch set
`define ISTREAM_CHUNKS 8

// queue depth in sets
`define ISTREAM_SETS 8

// instructions steered per dequeue
`define ISTREAM_WAYS 4

// fetch address after reset
`define ISTREAM_INIT_PC 32'h80000000

`endif

// File: istream_pkg.sv
`include "istream_macros.svh"

package istream_pkg;

    // one 16-bit parcel, low two bits 2'b11 start a 32-bit instr
    typedef logic [15:0] instr_chunk_t;

    // enqueue bundle from fetch
    typedef struct packed {
        logic [`ISTREAM_CHUNKS-1:0]         valid;
        instr_chunk_t [`ISTREAM_CHUNKS-1:0] chunks;
        logic [27:0]                        after_pc28;
    } fetch_set_t;

    // oldest set in the low half, next set in the high half
    typedef struct packed {
        logic [2*`ISTREAM_CHUNKS-1:0]         valid;
        instr_chunk_t [2*`ISTREAM_CHUNKS-1:0] chunks;
        logic [27:0]                          base_pc28;
        logic [27:0]                          mid_pc28;
    } stream_window_t;

    typedef union packed {
        logic [31:0] word;
        struct packed {
            instr_chunk_t upper;
            instr_chunk_t lower;
        } halves;
    } instr_word_u;

    typedef struct packed {
        logic        valid;
        logic        uncompressed;
        instr_word_u instr;
        logic [31:0] pc;
    } way_out_t;

    // wrap bit distinguishes full from empty
    typedef struct packed {
        logic                             wrap;
        logic [$clog2(`ISTREAM_SETS)-1:0] index;
    } stream_ptr_t;

endpackage

// File: istream_pq_lsb.sv
`include "istream_macros.svh"

module istream_pq_lsb #(
    parameter int WIDTH = 2 * `ISTREAM_CHUNKS
) (
    input  logic [WIDTH-1:0]         req_vec,
    output logic                     present,
    output logic [$clog2(WIDTH)-1:0] index,
    output logic [WIDTH-1:0]         cold_mask
);

    logic [WIDTH-1:0] lowest;
    logic [WIDTH-1:0] at_or_below;

    // isolate the lowest request bit
    assign lowest      = req_vec & (~req_vec + 1'b1);
    assign at_or_below = lowest | (lowest - 1'b1);

    assign present   = |req_vec;
    assign cold_mask = req_vec & ~at_or_below;

    // encode the one-hot bit, zero when nothing requests
    always_comb begin
        index = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (lowest[i]) begin
                index = i[$clog2(WIDTH)-1:0];
            end
        end
    end

endmodule

// File: istream_buffer.sv
`include "istream_macros.svh"

module istream_buffer (
    input  logic                           CLK,
    input  logic                           nRST,
    input  logic                           enq_valid,
    input  istream_pkg::fetch_set_t        enq_set,
    output logic                           enq_stall,
    input  logic                           deq_stall,
    input  logic [2*`ISTREAM_CHUNKS-1:0]   ack_vec,
    input  logic                           restart,
    input  logic [31:0]                    restart_pc,
    output istream_pkg::stream_window_t    window
);

    localparam int CH = `ISTREAM_CHUNKS;
    localparam int PTR_W = $bits(istream_pkg::stream_ptr_t);
    localparam logic [31:0] INIT_PC = `ISTREAM_INIT_PC;

    istream_pkg::fetch_set_t sets [`ISTREAM_SETS];

    istream_pkg::stream_ptr_t enq_ptr;
    istream_pkg::stream_ptr_t deq0_ptr;
    istream_pkg::stream_ptr_t deq1_ptr;
    logic [27:0]              base_pc28;

    logic [PTR_W-1:0]        set_count;
    logic                    full;
    logic                    occ0;
    logic                    occ1;
    logic                    enq_fire;
    logic                    deq_fire;
    logic                    retire0;
    logic                    retire1;
    istream_pkg::fetch_set_t set0;
    logic                    [CH-1:0] valid0;
    istream_pkg::fetch_set_t set1;
    logic                    [CH-1:0] valid1;

    // ------------------------------------------------------------
    // occupancy
    // ------------------------------------------------------------

    assign set_count = enq_ptr - deq0_ptr;
    assign full      = set_count == `ISTREAM_SETS;
    assign occ0      = set_count != '0;
    assign occ1      = set_count > 1;

    assign enq_stall = full;
    assign enq_fire  = enq_valid & ~full & ~restart;
    assign deq_fire  = ~deq_stall & ~restart;

    // ------------------------------------------------------------
    // dequeue window
    // ------------------------------------------------------------

    assign set0 = sets[deq0_ptr.index];
    assign set1 = sets[deq1_ptr.index];

    // unoccupied slots hold stale data, hide their valids
    assign valid0 = set0.valid & {CH{occ0}};
    assign valid1 = set1.valid & {CH{occ1}};

    assign window.valid     = {valid1, valid0};
    assign window.chunks    = {set1.chunks, set0.chunks};
    assign window.base_pc28 = base_pc28;
    assign window.mid_pc28  = set0.after_pc28;

    // a set retires once every remaining valid is acknowledged
    assign retire0 = occ0 & ((valid0 & ~ack_vec[CH-1:0]) == '0);
    assign retire1 = retire0 & occ1 & ((valid1 & ~ack_vec[2*CH-1:CH]) == '0);

    // ------------------------------------------------------------
    // set storage
    // ------------------------------------------------------------

    always_ff @(posedge CLK) begin
        if (enq_fire) begin
            sets[enq_ptr.index] <= enq_set;
        end
        // consumed chunks drop out of the set
        if (deq_fire & occ0) begin
            sets[deq0_ptr.index].valid <= valid0 & ~ack_vec[CH-1:0];
        end
        if (deq_fire & occ1) begin
            sets[deq1_ptr.index].valid <= valid1 & ~ack_vec[2*CH-1:CH];
        end
    end

    // pointers and base pc
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            enq_ptr   <= '0;
            deq0_ptr  <= '0;
            deq1_ptr  <= PTR_W'(1);
            base_pc28 <= INIT_PC[31:4];
        end else if (restart) begin
            enq_ptr   <= '0;
            deq0_ptr  <= '0;
            deq1_ptr  <= PTR_W'(1);
            base_pc28 <= restart_pc[31:4];
        end else begin
            if (enq_fire) begin
                enq_ptr <= enq_ptr + PTR_W'(1);
            end
            if (deq_fire & retire1) begin
                deq0_ptr  <= deq0_ptr + PTR_W'(2);
                deq1_ptr  <= deq1_ptr + PTR_W'(2);
                base_pc28 <= set1.after_pc28;
            end else if (deq_fire & retire0) begin
                deq0_ptr  <= deq0_ptr + PTR_W'(1);
                deq1_ptr  <= deq1_ptr + PTR_W'(1);
                base_pc28 <= set0.after_pc28;
            end
        end
    end

endmodule

// File: istream_way_select.sv
`include "istream_macros.svh"

module istream_way_select (
    input  istream_pkg::stream_window_t                  window,
    output logic [2*`ISTREAM_CHUNKS-1:0]                 ack_vec,
    output logic                                         deq_valid,
    output istream_pkg::way_out_t [`ISTREAM_WAYS-1:0]    deq_ways
);

    localparam int WIN = 2 * `ISTREAM_CHUNKS;
    localparam int IDX_W = $clog2(WIN);

    logic [WIN-1:0] ack_by_way [`ISTREAM_WAYS];

    // ------------------------------------------------------------
    // steering chain, one lower and one upper finder per way
    // ------------------------------------------------------------

    for (genvar w = 0; w < `ISTREAM_WAYS; w++) begin : g_way
        logic [WIN-1:0]           req;
        logic                     lower_present;
        logic [IDX_W-1:0]         lower_idx;
        logic [WIN-1:0]           lower_cold;
        logic                     upper_present;
        logic [IDX_W-1:0]         upper_idx;
        logic [WIN-1:0]           upper_cold;
        logic                     uncomp;
        logic                     ok;
        logic [WIN-1:0]           rest;
        logic [IDX_W-1:0]         pc_idx;
        logic [31:0]              pc;
        istream_pkg::instr_word_u word;

        // way 0 starts from the whole window
        if (w == 0) begin : g_head
            assign req = window.valid;
        end else begin : g_link
            assign req = g_way[w-1].rest;
        end

        istream_pq_lsb #(.WIDTH(WIN)) u_lower (
            .req_vec   (req),
            .present   (lower_present),
            .index     (lower_idx),
            .cold_mask (lower_cold)
        );

        // upper half is the next valid chunk after the lower
        istream_pq_lsb #(.WIDTH(WIN)) u_upper (
            .req_vec   (lower_cold),
            .present   (upper_present),
            .index     (upper_idx),
            .cold_mask (upper_cold)
        );

        assign uncomp = window.chunks[lower_idx][1:0] == 2'b11;
        assign ok     = lower_present & (~uncomp | upper_present);

        // failed way starves everything after it
        assign rest = !ok ? '0 : (uncomp ? upper_cold : lower_cold);

        assign ack_by_way[w] = !ok ? '0 :
            ((WIN'(1) << lower_idx) | (uncomp ? (WIN'(1) << upper_idx) : '0));

        // pc comes from the chunk holding the set data
        assign pc_idx = uncomp ? upper_idx : lower_idx;
        assign pc = {pc_idx[IDX_W-1] ? window.mid_pc28 : window.base_pc28,
                     pc_idx[IDX_W-2:0], 1'b0};

        assign word.halves.lower = window.chunks[lower_idx];
        assign word.halves.upper = window.chunks[upper_idx];

        assign deq_ways[w] = '{ok, uncomp, word, pc};
    end

    always_comb begin
        ack_vec = '0;
        for (int i = 0; i < `ISTREAM_WAYS; i++) begin
            ack_vec = ack_vec | ack_by_way[i];
        end
    end

    assign deq_valid = deq_ways[0].valid;

endmodule

// File: istream.sv
`include "istream_macros.svh"

module istream (
    input  logic                                       CLK,
    input  logic                                       nRST,

    // fetch side
    input  logic                                       enq_valid,
    input  istream_pkg::fetch_set_t                    enq_set,
    output logic                                       enq_stall,

    // decode side
    output logic                                       deq_valid,
    output istream_pkg::way_out_t [`ISTREAM_WAYS-1:0]  deq_ways,
    input  logic                                       deq_stall,

    // redirect
    input  logic                                       restart,
    input  logic [31:0]                                restart_pc
);

    istream_pkg::stream_window_t          window;
    logic [2*`ISTREAM_CHUNKS-1:0]         ack_vec;

    // ------------------------------------------------------------
    // set queue and two-set window
    // ------------------------------------------------------------

    istream_buffer u_buffer (
        .CLK        (CLK),
        .nRST       (nRST),
        .enq_valid  (enq_valid),
        .enq_set    (enq_set),
        .enq_stall  (enq_stall),
        .deq_stall  (deq_stall),
        .ack_vec    (ack_vec),
        .restart    (restart),
        .restart_pc (restart_pc),
        .window     (window)
    );

    // steering onto decode ways
    istream_way_select u_way_select (
        .window    (window),
        .ack_vec   (ack_vec),
        .deq_valid (deq_valid),
        .deq_ways  (deq_ways)
    );

endmodule

// File: istream_asserts.sv
`include "istream_macros.svh"

module istream_asserts (
    input logic                                      CLK,
    input logic                                      nRST,
    input logic                                      enq_stall,
    input logic                                      deq_valid,
    input istream_pkg::way_out_t [`ISTREAM_WAYS-1:0] deq_ways,
    input logic                                      restart,
    input istream_pkg::stream_ptr_t                  enq_ptr,
    input istream_pkg::stream_ptr_t                  deq0_ptr
);

    logic [`ISTREAM_WAYS-1:0] way_valid;
    logic [3:0]               set_count;

    always_comb begin
        for (int w = 0; w < `ISTREAM_WAYS; w++) begin
            way_valid[w] = deq_ways[w].valid;
        end
    end

    assign set_count = enq_ptr - deq0_ptr;

    // valid ways fill from way 0 upward
    assert property (@(posedge CLK) disable iff (!nRST)
        ((way_valid + 1'b1) & way_valid) == '0)
        else $error("way valids are not a prefix");

    assert property (@(posedge CLK) disable iff (!nRST) deq_valid == way_valid[0])
        else $error("deq_valid differs from way 0 valid");

    assert property (@(posedge CLK) disable iff (!nRST) set_count <= `ISTREAM_SETS)
        else $error("set count above queue depth");

    // queue is empty right after a restart
    assert property (@(posedge CLK) disable iff (!nRST) restart |=> !enq_stall)
        else $error("enq_stall high after restart");

endmodule

bind istream istream_asserts u_asserts (
    .CLK       (CLK),
    .nRST      (nRST),
    .enq_stall (enq_stall),
    .deq_valid (deq_valid),
    .deq_ways  (deq_ways),
    .restart   (restart),
    .enq_ptr   (u_buffer.enq_ptr),
    .deq0_ptr  (u_buffer.deq0_ptr)
);

// File: tb_clock.sv
module tb_clock #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    // release on a falling edge, clear of the sampling edge
    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
    end

endmodule

// File: tb_istream.sv
`include "istream_macros.svh"

module tb_istream;

    localparam int TEST_CYCLES = 60;
    localparam logic [31:0] INIT_PC = `ISTREAM_INIT_PC;

    logic                                      CLK;
    logic                                      nRST;
    logic                                      enq_valid;
    istream_pkg::fetch_set_t                   enq_set;
    logic                                      enq_stall;
    logic                                      deq_valid;
    istream_pkg::way_out_t [`ISTREAM_WAYS-1:0] deq_ways;
    logic                                      deq_stall;
    logic                                      restart;
    logic [31:0]                               restart_pc;

    // sets the model believes are queued in age order
    istream_pkg::fetch_set_t model_q[$];
    logic [27:0]             model_base;
    int                      errors;
    int                      tests_run;
    int                      tests_failed;

    tb_clock #(.PERIOD(40), .RESET_CYCLES(3)) u_clock (
        .CLK  (CLK),
        .nRST (nRST)
    );

    istream DUT (
        .CLK        (CLK),
        .nRST       (nRST),
        .enq_valid  (enq_valid),
        .enq_set    (enq_set),
        .enq_stall  (enq_stall),
        .deq_valid  (deq_valid),
        .deq_ways   (deq_ways),
        .deq_stall  (deq_stall),
        .restart    (restart),
        .restart_pc (restart_pc)
    );

    // ------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------

    function automatic istream_pkg::instr_chunk_t random_chunk(input bit uncomp);
        istream_pkg::instr_chunk_t c;
        c = 16'($urandom);
        if (uncomp) begin
            c[1:0] = 2'b11;
        end else if (c[1:0] == 2'b11) begin
            c[0] = 1'b0;
        end
        return c;
    endfunction

    function automatic istream_pkg::fetch_set_t build_set(input logic [7:0] valid,
            input logic [7:0] uncomp, input logic [27:0] after_pc28);
        istream_pkg::fetch_set_t s;
        s.valid      = valid;
        s.after_pc28 = after_pc28;
        for (int c = 0; c < `ISTREAM_CHUNKS; c++) begin
            s.chunks[c] = random_chunk(uncomp[c]);
        end
        return s;
    endfunction

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------

    // steer the two oldest model sets onto the ways from the lowest chunk up
    function automatic void predict_ways(output istream_pkg::way_out_t [`ISTREAM_WAYS-1:0] ways,
            output logic [15:0] ack);
        logic [15:0]               v;
        istream_pkg::instr_chunk_t ch [16];
        int                        pos;
        int                        lo;
        int                        up;
        int                        car;
        bit                        stop;
        bit                        unc;
        v    = '0;
        ack  = '0;
        ways = '0;
        pos  = 0;
        stop = 1'b0;
        for (int i = 0; i < 16; i++) begin
            ch[i] = '0;
            if (model_q.size() > i / 8) begin
                v[i]  = model_q[i / 8].valid[i % 8];
                ch[i] = model_q[i / 8].chunks[i % 8];
            end
        end
        for (int w = 0; w < `ISTREAM_WAYS; w++) begin
            lo = pos;
            while (lo < 16 && !v[lo]) begin
                lo++;
            end
            up = lo + 1;
            while (up < 16 && !v[up]) begin
                up++;
            end
            if (lo == 16 || (ch[lo][1:0] == 2'b11 && up == 16)) begin
                stop = 1'b1;
            end
            if (!stop) begin
                unc = ch[lo][1:0] == 2'b11;
                car = unc ? up : lo;
                ways[w].valid              = 1'b1;
                ways[w].uncompressed       = unc;
                ways[w].instr.halves.lower = ch[lo];
                ways[w].instr.halves.upper = unc ? ch[up] : '0;
                ways[w].pc = {(car >= 8) ? model_q[0].after_pc28 : model_base,
                              3'(car % 8), 1'b0};
                ack[lo]  = 1'b1;
                ack[car] = 1'b1;
                pos = car + 1;
            end
        end
    endfunction

    task automatic model_edge(input bit en, input istream_pkg::fetch_set_t s,
            input bit dstall, input bit rst, input logic [31:0] rpc);
        istream_pkg::way_out_t [`ISTREAM_WAYS-1:0] ways;
        logic [15:0]                               ack;
        int                                        n;
        predict_ways(ways, ack);
        n = model_q.size();
        if (rst) begin
            model_q.delete();
            model_base = rpc[31:4];
        end else begin
            if (!dstall) begin
                for (int i = 0; i < 2 && i < n; i++) begin
                    model_q[i].valid = model_q[i].valid & ~ack[8*i +: 8];
                end
                // empty oldest set retires and the next one may follow it
                if (n > 0 && model_q[0].valid == '0) begin
                    model_base = model_q[0].after_pc28;
                    void'(model_q.pop_front());
                    if (n > 1 && model_q[0].valid == '0) begin
                        model_base = model_q[0].after_pc28;
                        void'(model_q.pop_front());
                    end
                end
            end
            if (en && n < `ISTREAM_SETS) begin
                model_q.push_back(s);
            end
        end
    endtask

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------

    task automatic report_mismatch(input string name, input logic [65:0] got,
            input logic [65:0] exp);
        errors++;
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic expect_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_mismatch(name, 66'(got), 66'(exp));
        end
    endtask

    task automatic expect_way(input int w, input bit valid, input logic [31:0] pc);
        expect_bit($sformatf("deq_ways[%0d].valid", w), deq_ways[w].valid, valid);
        if (valid && deq_ways[w].pc !== pc) begin
            report_mismatch($sformatf("deq_ways[%0d].pc", w), 66'(deq_ways[w].pc), 66'(pc));
        end
    endtask

    task automatic check_outputs();
        istream_pkg::way_out_t [`ISTREAM_WAYS-1:0] exp;
        logic [15:0]                               ack;
        string                                     nm;
        predict_ways(exp, ack);
        expect_bit("enq_stall", enq_stall, model_q.size() == `ISTREAM_SETS);
        expect_bit("deq_valid", deq_valid, exp[0].valid);
        for (int w = 0; w < `ISTREAM_WAYS; w++) begin
            nm = $sformatf("deq_ways[%0d]", w);
            expect_bit({nm, ".valid"}, deq_ways[w].valid, exp[w].valid);
            if (deq_ways[w].valid === 1'b1 && exp[w].valid) begin
                expect_bit({nm, ".uncompressed"}, deq_ways[w].uncompressed,
                           exp[w].uncompressed);
                if (deq_ways[w].pc !== exp[w].pc) begin
                    report_mismatch({nm, ".pc"}, 66'(deq_ways[w].pc), 66'(exp[w].pc));
                end
                // upper half only carries meaning for a 32-bit instruction
                if (exp[w].uncompressed && deq_ways[w].instr.word !== exp[w].instr.word) begin
                    report_mismatch({nm, ".instr"}, 66'(deq_ways[w].instr.word),
                                    66'(exp[w].instr.word));
                end else if (deq_ways[w].instr.halves.lower !== exp[w].instr.halves.lower) begin
                    report_mismatch({nm, ".instr.lower"}, 66'(deq_ways[w].instr.halves.lower),
                                    66'(exp[w].instr.halves.lower));
                end
            end
        end
    endtask

    // drive on the falling edge, model on the rising edge, check on the next fall
    task automatic run_cycle(input bit en, input istream_pkg::fetch_set_t s, input bit dstall,
            input bit rst = 1'b0, input logic [31:0] rpc = '0);
        enq_valid  = en;
        enq_set    = s;
        deq_stall  = dstall;
        restart    = rst;
        restart_pc = rpc;
        @(posedge CLK);
        model_edge(en, s, dstall, rst, rpc);
        @(negedge CLK);
        check_outputs();
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            run_cycle(1'b0, '0, 1'b0);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    // ------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------

    task automatic test_reset();
        int e0;
        e0 = errors;
        check_outputs();
        expect_bit("enq_stall", enq_stall, 1'b0);
        expect_bit("deq_valid", deq_valid, 1'b0);
        for (int w = 0; w < `ISTREAM_WAYS; w++) begin
            expect_way(w, 1'b0, '0);
        end
        finish_test("reset", e0);
    endtask

    task automatic test_compressed();
        int e0;
        e0 = errors;
        run_cycle(1'b1, build_set(8'hff, 8'h00, 28'h8000001), 1'b0);
        for (int w = 0; w < `ISTREAM_WAYS; w++) begin
            expect_way(w, 1'b1, INIT_PC + 32'(2 * w));
        end
        idle(1);
        for (int w = 0; w < `ISTREAM_WAYS; w++) begin
            expect_way(w, 1'b1, INIT_PC + 32'(8 + 2 * w));
        end
        idle(1);
        expect_bit("deq_valid", deq_valid, 1'b0);
        finish_test("compressed", e0);
    endtask

    task automatic test_straddle();
        int e0;
        e0 = errors;
        // chunks 0, 3 and 7 open 32-bit instructions and 7 pairs with the next set
        run_cycle(1'b1, build_set(8'hff, 8'b1000_1001, 28'h8000002), 1'b1);
        run_cycle(1'b1, build_set(8'hff, 8'h00, 28'h8000003), 1'b1);
        expect_way(0, 1'b1, 32'h80000012);
        idle(1);
        expect_way(1, 1'b1, 32'h80000020);
        expect_bit("deq_ways[1].uncompressed", deq_ways[1].uncompressed, 1'b1);
        expect_way(2, 1'b1, 32'h80000022);
        idle(1);
        expect_way(0, 1'b1, 32'h80000026);
        idle(2);
        finish_test("straddle", e0);
    endtask

    task automatic test_missing_upper();
        istream_pkg::fetch_set_t d;
        int                      e0;
        e0 = errors;
        d  = build_set(8'b1111_1110, 8'h00, 28'h8000005);
        run_cycle(1'b1, build_set(8'b1000_0011, 8'b1000_0000, 28'h8000004), 1'b0);
        expect_way(1, 1'b1, 32'h80000032);
        expect_way(2, 1'b0, '0);
        expect_way(3, 1'b0, '0);
        idle(1);
        expect_bit("deq_valid", deq_valid, 1'b0);
        run_cycle(1'b1, d, 1'b0);
        expect_way(0, 1'b1, 32'h80000042);
        if (deq_ways[0].instr.halves.upper !== d.chunks[1]) begin
            report_mismatch("deq_ways[0].instr.upper", 66'(deq_ways[0].instr.halves.upper),
                            66'(d.chunks[1]));
        end
        idle(2);
        finish_test("missing_upper", e0);
    endtask

    task automatic test_backpressure();
        istream_pkg::way_out_t [`ISTREAM_WAYS-1:0] held;
        istream_pkg::fetch_set_t                   s;
        int                                        e0;
        e0 = errors;
        for (int i = 0; i < `ISTREAM_SETS; i++) begin
            run_cycle(1'b1, build_set(8'hff, 8'($urandom) & 8'h7f, 28'h8000006 + 28'(i)), 1'b1);
        end
        expect_bit("enq_stall", enq_stall, 1'b1);
        held = deq_ways;
        // fetch holds its set while stalled
        s = build_set(8'hff, 8'h00, 28'h8000010);
        run_cycle(1'b1, s, 1'b1);
        run_cycle(1'b1, s, 1'b1);
        expect_bit("enq_stall", enq_stall, 1'b1);
        for (int w = 0; w < `ISTREAM_WAYS; w++) begin
            if (deq_ways[w] !== held[w]) begin
                report_mismatch($sformatf("deq_ways[%0d]", w), deq_ways[w], held[w]);
            end
        end
        idle(18);
        expect_bit("deq_valid", deq_valid, 1'b0);
        expect_bit("enq_stall", enq_stall, 1'b0);
        finish_test("backpressure", e0);
    endtask

    task automatic test_restart();
        int e0;
        e0 = errors;
        // one short of full so a leaked enqueue would raise enq_stall
        for (int i = 0; i < `ISTREAM_SETS - 1; i++) begin
            run_cycle(1'b1, build_set(8'hff, 8'h00, 28'h8000020 + 28'(i)), 1'b1);
        end
        // enqueue in the same cycle loses to the restart
        run_cycle(1'b1, build_set(8'hff, 8'h00, 28'h0000fff), 1'b0, 1'b1, 32'h00001238);
        expect_bit("deq_valid", deq_valid, 1'b0);
        expect_bit("enq_stall", enq_stall, 1'b0);
        run_cycle(1'b1, build_set(8'hff, 8'h00, 28'h0000124), 1'b0);
        expect_way(0, 1'b1, 32'h00001230);
        idle(2);
        expect_bit("deq_valid", deq_valid, 1'b0);
        finish_test("restart", e0);
    endtask

    initial begin
        void'($urandom(20182));
        enq_valid    = 1'b0;
        enq_set      = '0;
        deq_stall    = 1'b0;
        restart      = 1'b0;
        restart_pc   = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        model_base   = INIT_PC[31:4];
        wait (nRST === 1'b1);
        @(negedge CLK);
        test_reset();
        test_compressed();
        test_straddle();
        test_missing_upper();
        test_backpressure();
        test_restart();
        $display("tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // watchdog sized from the test lengths plus a margin
    initial begin
        #((TEST_CYCLES + 20) * 40);
        $display("timeout: tests did not finish within %0d cycles", TEST_CYCLES + 20);
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: istream.f
+incdir+.
istream_pkg.sv
istream_pq_lsb.sv
istream_buffer.sv
istream_way_select.sv
istream.sv
istream_asserts.sv
tb_clock.sv
tb_istream.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the istream testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_istream -f istream.f -o tb_istream_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_istream_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF "** FAIL **" "$LOG"; then
    exit 1
fi
exit 0
